// ==== Bender.yml ====
package:
  name: ac_out

export_include_dirs:
  - common

sources:
  - files:
      - common/ac_pixel_pkg.sv
      - common/ac_ctrl_pkg.sv
      - verilog/ac_align_fifo.sv
      - ac_outbuf/ac_lane_fifo.sv
      - ac_outbuf/ac_outbuf.sv
      - verilog/ac_stream_tx.sv
      - verilog/ac_out_top.sv
  - target: test
    files:
      - dv/ac_out_checker.sv
      - dv/ac_out_tb.sv

// ==== ac_outbuf/ac_lane_fifo.sv ====
// ##########################################################
// Lane FIFO, synchronous with first-word fall-through
// ##########################################################

module ac_lane_fifo #(
    parameter int DEPTH = 8,
    parameter int WIDTH = 24
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             wr,
    input  logic [WIDTH-1:0] wdata,
    input  logic             rd,
    output logic [WIDTH-1:0] rdata,
    output logic             empty,
    output logic             full
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    // Head entry is visible without a read
    assign rdata = mem[rd_ptr];
    assign empty = (count == '0);
    assign full  = (count == CNT_W'(DEPTH));

    always_ff @(posedge clk) begin
        if (wr) begin
            mem[wr_ptr] <= wdata;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + CNT_W'(wr) - CNT_W'(rd);
        end
    end

endmodule

// ==== ac_outbuf/ac_outbuf.sv ====
// ##########################################################
// Output buffer, steers pixels of a row across lane FIFOs
// Pads the last word of a row with the row's final pixel
// and presents all lane heads as one wide word
// ##########################################################

`include "ac_cfg.svh"

module ac_outbuf (
    input  logic                    clk,
    input  logic                    rst_n,
    output logic                    al_rd,
    input  ac_pixel_pkg::pix_t      al_pix,
    input  logic                    al_empty,
    input  logic                    ob_rd,
    output ac_pixel_pkg::ac_word_t  ob_word,
    output logic                    ob_empty
);

    localparam int N_PAR  = `AC_N_PAR;
    localparam int IMG_W  = `AC_IMG_W;
    localparam int LANE_W = (N_PAR > 1) ? $clog2(N_PAR) : 1;
    localparam int COL_W  = (IMG_W > 1) ? $clog2(IMG_W) : 1;

    // Staging register
    ac_pixel_pkg::pix_t stg_pix;
    logic               stg_valid;
    logic               stg_drain;

    logic [COL_W-1:0]   col_cnt;
    logic [LANE_W-1:0]  lane_idx;
    logic               row_end;

    ac_ctrl_pkg::fill_mode_e fill;

    logic [N_PAR-1:0]   lane_wr;
    logic [N_PAR-1:0]   lane_empty;
    logic [N_PAR-1:0]   lane_full;
    logic               lanes_ready;

    assign lanes_ready = !(|lane_full);
    assign stg_drain   = stg_valid && lanes_ready;
    assign al_rd       = !al_empty && (!stg_valid || stg_drain);

    assign row_end = (col_cnt == COL_W'(IMG_W - 1));
    assign fill    = row_end ? ac_ctrl_pkg::FILL_ROWEND : ac_ctrl_pkg::FILL_NEXT;

    assign ob_empty = |lane_empty;

    always_ff @(posedge clk) begin
        if (al_rd) begin
            stg_pix <= al_pix;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            stg_valid <= 1'b0;
        end else if (al_rd) begin
            stg_valid <= 1'b1;
        end else if (stg_drain) begin
            stg_valid <= 1'b0;
        end
    end

    // Position in the row and the lane for the next pixel
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            col_cnt  <= '0;
            lane_idx <= '0;
        end else if (stg_drain) begin
            col_cnt <= row_end ? '0 : col_cnt + 1'b1;
            if (row_end || lane_idx == LANE_W'(N_PAR - 1)) begin
                lane_idx <= '0;
            end else begin
                lane_idx <= lane_idx + 1'b1;
            end
        end
    end

    for (genvar j = 0; j < N_PAR; j++) begin : g_lane
        // At row end the current lane and every lane above it take the pixel
        assign lane_wr[j] = stg_drain &&
                            ((fill == ac_ctrl_pkg::FILL_ROWEND) ? (LANE_W'(j) >= lane_idx)
                                                                : (LANE_W'(j) == lane_idx));

        ac_lane_fifo #(
            .DEPTH (`AC_LANE_DEPTH),
            .WIDTH (`AC_PIX_W)
        ) i_lane_fifo (
            .clk   (clk),
            .rst_n (rst_n),
            .wr    (lane_wr[j]),
            .wdata (stg_pix),
            .rd    (ob_rd),
            .rdata (ob_word[N_PAR-1-j]),
            .empty (lane_empty[j]),
            .full  (lane_full[j])
        );
    end

endmodule

// ==== common/ac_cfg.svh ====
// ##########################################################
// Output-side configuration of the access-control block
// Image geometry, lane count and FIFO depths
// ##########################################################

`ifndef AC_CFG_SVH
`define AC_CFG_SVH

// Bits per RGB pixel
`define AC_PIX_W 24

// Pixels per row, odd on purpose so rows end in a padded word
`define AC_IMG_W 5

// Rows per frame
`define AC_IMG_H 3

// Parallel lanes in the wide output word
`define AC_N_PAR 2

// Alignment FIFO entries
`define AC_ALIGN_DEPTH 4

// Entries per lane FIFO
`define AC_LANE_DEPTH 8

`endif

// ==== common/ac_ctrl_pkg.sv ====
// ##########################################################
// Control encodings for lane steering and stream transmit
// ##########################################################

package ac_ctrl_pkg;

    // Lane write selection for a staged pixel
    typedef enum logic {
        FILL_NEXT   = 1'b0,
        FILL_ROWEND = 1'b1
    } fill_mode_e;

    // Output register occupancy
    typedef enum logic {
        TX_EMPTY = 1'b0,
        TX_HOLD  = 1'b1
    } tx_state_e;

endpackage

// ==== common/ac_pixel_pkg.sv ====
// ##########################################################
// Data-path types of the access-control output side
// ##########################################################

`include "ac_cfg.svh"

package ac_pixel_pkg;

    // One RGB pixel
    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } pix_t;

    // Wide lane word, highest slot carries the earliest pixel
    typedef pix_t [`AC_N_PAR-1:0] ac_word_t;

    // Output beat with frame and row markers
    typedef struct packed {
        ac_word_t data;
        logic     tuser;
        logic     tlast;
    } ac_beat_t;

endpackage

// ==== dv/ac_out_checker.sv ====
// ##########################################################
// Handshake and reset assertions for the output side
// Bound to the top level of the access-control block
// ##########################################################

module ac_out_checker (
    input logic                   clk,
    input logic                   rst_n,
    input logic                   out_valid,
    input ac_pixel_pkg::ac_beat_t out_beat,
    input logic                   out_tready
);

    // Number of failed assertions
    int fail_cnt;

    // Output idle during reset and in the first cycle after it
    a_reset_idle: assert property (@(posedge clk) (!rst_n || $rose(rst_n)) |-> !out_valid)
        else begin
            $error("out_valid high during or right after reset");
            fail_cnt++;
        end

    // Beat held steady while the sink stalls
    a_beat_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (out_valid && !out_tready) |=> $stable(out_beat))
        else begin
            $error("out_beat changed while waiting for out_tready");
            fail_cnt++;
        end

    // Valid only drops after a transfer
    a_valid_held: assert property (@(posedge clk) disable iff (!rst_n)
        (out_valid && !out_tready) |=> out_valid)
        else begin
            $error("out_valid dropped without a transfer");
            fail_cnt++;
        end

endmodule

bind ac_out_top ac_out_checker i_checker (
    .clk        (clk),
    .rst_n      (rst_n),
    .out_valid  (out_valid),
    .out_beat   (out_beat),
    .out_tready (out_tready)
);

// ==== dv/ac_out_tb.sv ====
// ##########################################################
// Testbench for the access-control output side
// Reference beats are built per frame and a monitor compares
// ##########################################################

`include "ac_cfg.svh"

module ac_out_tb;

    localparam int FRAME_PIX = `AC_IMG_W * `AC_IMG_H;
    localparam int TIMEOUT   = 2000;

    logic                   clk;
    logic                   rst_n;
    logic                   in_valid;
    ac_pixel_pkg::pix_t     in_pix;
    logic                   in_ready;
    logic                   out_valid;
    ac_pixel_pkg::ac_beat_t out_beat;
    logic                   out_tready;

    ac_pixel_pkg::ac_beat_t exp_q[$];
    ac_pixel_pkg::pix_t     frame [FRAME_PIX];
    int err_cnt;
    int beat_cnt;
    int tuser_cnt;
    int err_start;
    int beat_start;
    int tuser_start;
    int pass_tests;
    int fail_tests;
    int stall_left;
    int assert_seen;
    bit gaps_on;
    bit bp_on;
    bit saw_full;

    ac_out_top i_ac_out_top (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .in_pix     (in_pix),
        .in_ready   (in_ready),
        .out_valid  (out_valid),
        .out_beat   (out_beat),
        .out_tready (out_tready)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Expected beats of one frame appended to the queue
    function automatic void build_expected(input ac_pixel_pkg::pix_t pix [FRAME_PIX]);
        ac_pixel_pkg::ac_beat_t beat;
        int col;
        for (int row = 0; row < `AC_IMG_H; row++) begin
            for (int w = 0; w * `AC_N_PAR < `AC_IMG_W; w++) begin
                for (int s = 0; s < `AC_N_PAR; s++) begin
                    // Short last group repeats the row's final pixel
                    col = w * `AC_N_PAR + s;
                    if (col > `AC_IMG_W - 1) begin
                        col = `AC_IMG_W - 1;
                    end
                    beat.data[`AC_N_PAR-1-s] = pix[row * `AC_IMG_W + col];
                end
                beat.tuser = (row == 0) && (w == 0);
                beat.tlast = ((w + 1) * `AC_N_PAR >= `AC_IMG_W);
                exp_q.push_back(beat);
            end
        end
    endfunction

    task automatic compare_word(input ac_pixel_pkg::ac_word_t got,
                                input ac_pixel_pkg::ac_word_t exp);
        if (got !== exp) begin
            $display("ERROR %0t: beat %0d data %h, expected %h", $time, beat_cnt, got, exp);
            err_cnt++;
        end
    endtask

    task automatic compare_bit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("ERROR %0t: %s is %b, expected %b", $time, what, got, exp);
            err_cnt++;
        end
    endtask

    task automatic compare_beat(input ac_pixel_pkg::ac_beat_t got,
                                input ac_pixel_pkg::ac_beat_t exp);
        compare_word(got.data, exp.data);
        compare_bit(got.tuser, exp.tuser, "tuser");
        compare_bit(got.tlast, exp.tlast, "tlast");
    endtask

    task automatic abort_run(input string what);
        $display("Timed out waiting for %s at time %0t", what, $time);
        $display("Regression failed");
        $finish;
    endtask

    // Monitor of output transfers
    always @(posedge clk) begin
        if (rst_n && out_valid && out_tready) begin
            if (exp_q.size() == 0) begin
                $display("ERROR %0t: beat %0d arrived with none expected", $time, beat_cnt);
                err_cnt++;
            end else begin
                compare_beat(out_beat, exp_q.pop_front());
            end
            if (out_beat.tuser) begin
                tuser_cnt++;
            end
            beat_cnt++;
        end
        if (rst_n && !in_ready) begin
            saw_full = 1'b1;
        end
    end

    // Sink stalls with long low stretches now and then
    always @(negedge clk) begin
        if (!bp_on) begin
            out_tready = 1'b1;
        end else if (stall_left > 0) begin
            out_tready = 1'b0;
            stall_left--;
        end else if ($urandom_range(9) == 0) begin
            stall_left = 16 + $urandom_range(15);
            out_tready = 1'b0;
        end else begin
            out_tready = $urandom_range(1);
        end
    end

    task automatic push_pixel(input ac_pixel_pkg::pix_t p);
        int   waited;
        logic taken;
        waited = 0;
        taken  = 1'b0;
        if (gaps_on && $urandom_range(2) == 0) begin
            in_valid = 1'b0;
            repeat ($urandom_range(4, 1)) @(negedge clk);
        end
        in_valid = 1'b1;
        in_pix   = p;
        while (!taken) begin
            @(posedge clk);
            taken = in_ready;
            waited++;
            if (!taken && waited > TIMEOUT) begin
                abort_run("in_ready");
            end
        end
        @(negedge clk);
    endtask

    task automatic send_frames(input int n_frames);
        logic [31:0] rnd;
        int          waited;
        for (int f = 0; f < n_frames; f++) begin
            foreach (frame[i]) begin
                rnd      = $urandom();
                frame[i] = rnd[23:0];
            end
            build_expected(frame);
            foreach (frame[i]) begin
                push_pixel(frame[i]);
            end
        end
        in_valid = 1'b0;
        waited   = 0;
        while (exp_q.size() > 0) begin
            @(negedge clk);
            waited++;
            if (waited > TIMEOUT) begin
                abort_run("output beats");
            end
        end
        // Idle a little so stray extra beats show up in this test
        repeat (8) @(negedge clk);
    endtask

    task automatic start_test();
        err_start   = err_cnt;
        beat_start  = beat_cnt;
        tuser_start = tuser_cnt;
    endtask

    task automatic end_test(input string name);
        err_cnt     += i_ac_out_top.i_checker.fail_cnt - assert_seen;
        assert_seen  = i_ac_out_top.i_checker.fail_cnt;
        if (err_cnt == err_start) begin
            pass_tests++;
        end else begin
            fail_tests++;
        end
        $display("Test %s: %0d beats, %0d errors", name, beat_cnt - beat_start,
                 err_cnt - err_start);
    endtask

    initial begin
        void'($urandom(32'hcfda));
        rst_n       = 1'b0;
        in_valid    = 1'b0;
        in_pix      = '0;
        out_tready  = 1'b1;
        gaps_on     = 1'b0;
        bp_on       = 1'b0;
        saw_full    = 1'b0;
        stall_left  = 0;
        err_cnt     = 0;
        beat_cnt    = 0;
        tuser_cnt   = 0;
        pass_tests  = 0;
        fail_tests  = 0;
        assert_seen = 0;

        start_test();
        repeat (3) begin
            @(posedge clk);
            compare_bit(in_ready, 1'b1, "in_ready in reset");
            compare_bit(out_valid, 1'b0, "out_valid in reset");
        end
        @(negedge clk);
        rst_n = 1'b1;
        @(posedge clk);
        compare_bit(in_ready, 1'b1, "in_ready after reset");
        compare_bit(out_valid, 1'b0, "out_valid after reset");
        @(negedge clk);
        end_test("reset state");

        start_test();
        send_frames(1);
        end_test("single frame");

        start_test();
        gaps_on = 1'b1;
        send_frames(2);
        gaps_on = 1'b0;
        end_test("input gaps");

        // Three frames so the stalls can back up into the input
        start_test();
        saw_full = 1'b0;
        bp_on    = 1'b1;
        send_frames(3);
        bp_on    = 1'b0;
        if (!saw_full) begin
            $display("Back-pressure never made in_ready drop");
            err_cnt++;
        end
        end_test("back-pressure");

        start_test();
        send_frames(3);
        if (tuser_cnt - tuser_start != 3) begin
            $display("ERROR %0t: %0d frame starts seen, expected 3", $time,
                     tuser_cnt - tuser_start);
            err_cnt++;
        end
        end_test("back-to-back");

        $display("Tests passed %0d, failed %0d, errors %0d", pass_tests, fail_tests, err_cnt);
        if (fail_tests == 0 && err_cnt == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// ==== filelist.f ====
+incdir+common
common/ac_pixel_pkg.sv
common/ac_ctrl_pkg.sv
verilog/ac_align_fifo.sv
ac_outbuf/ac_lane_fifo.sv
ac_outbuf/ac_outbuf.sv
verilog/ac_stream_tx.sv
verilog/ac_out_top.sv
dv/ac_out_checker.sv
dv/ac_out_tb.sv

// ==== verilog/ac_align_fifo.sv ====
// ##########################################################
// Alignment FIFO between the pixel source and the buffer
// Valid/ready write side, rd/empty read side
// ##########################################################

`include "ac_cfg.svh"

module ac_align_fifo (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                in_valid,
    input  ac_pixel_pkg::pix_t  in_pix,
    output logic                in_ready,
    input  logic                al_rd,
    output ac_pixel_pkg::pix_t  al_pix,
    output logic                al_empty
);

    localparam int DEPTH = `AC_ALIGN_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    ac_pixel_pkg::pix_t mem [DEPTH];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [CNT_W-1:0]   count;
    logic               full;
    logic               wr_en;

    assign full     = (count == CNT_W'(DEPTH));
    assign al_empty = (count == '0);
    assign al_pix   = mem[rd_ptr];

    // A pop in the same cycle frees the slot for the incoming pixel
    assign in_ready = !full || al_rd;
    assign wr_en    = in_valid && in_ready;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= in_pix;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (al_rd) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + CNT_W'(wr_en) - CNT_W'(al_rd);
        end
    end

endmodule

// ==== verilog/ac_out_top.sv ====
// ##########################################################
// Output side of the access-control block
// Alignment FIFO, lane buffer and stream transmitter
// ##########################################################

module ac_out_top (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    in_valid,
    input  ac_pixel_pkg::pix_t      in_pix,
    output logic                    in_ready,
    output logic                    out_valid,
    output ac_pixel_pkg::ac_beat_t  out_beat,
    input  logic                    out_tready
);

    ac_pixel_pkg::pix_t     al_pix;
    logic                   al_empty;
    logic                   al_rd;

    ac_pixel_pkg::ac_word_t ob_word;
    logic                   ob_empty;
    logic                   ob_rd;

    ac_align_fifo i_align_fifo (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (in_valid),
        .in_pix   (in_pix),
        .in_ready (in_ready),
        .al_rd    (al_rd),
        .al_pix   (al_pix),
        .al_empty (al_empty)
    );

    ac_outbuf i_outbuf (
        .clk      (clk),
        .rst_n    (rst_n),
        .al_rd    (al_rd),
        .al_pix   (al_pix),
        .al_empty (al_empty),
        .ob_rd    (ob_rd),
        .ob_word  (ob_word),
        .ob_empty (ob_empty)
    );

    ac_stream_tx i_stream_tx (
        .clk        (clk),
        .rst_n      (rst_n),
        .ob_word    (ob_word),
        .ob_empty   (ob_empty),
        .ob_rd      (ob_rd),
        .out_valid  (out_valid),
        .out_beat   (out_beat),
        .out_tready (out_tready)
    );

endmodule

// ==== verilog/ac_stream_tx.sv ====
// ##########################################################
// Stream transmitter, turns wide words into output beats
// Marks frame start with tuser and row end with tlast
// ##########################################################

`include "ac_cfg.svh"

module ac_stream_tx (
    input  logic                    clk,
    input  logic                    rst_n,
    input  ac_pixel_pkg::ac_word_t  ob_word,
    input  logic                    ob_empty,
    output logic                    ob_rd,
    output logic                    out_valid,
    output ac_pixel_pkg::ac_beat_t  out_beat,
    input  logic                    out_tready
);

    // Words per row, rounded up
    localparam int WPR  = (`AC_IMG_W + `AC_N_PAR - 1) / `AC_N_PAR;
    localparam int WC_W = (WPR > 1) ? $clog2(WPR) : 1;
    localparam int RC_W = (`AC_IMG_H > 1) ? $clog2(`AC_IMG_H) : 1;

    ac_ctrl_pkg::tx_state_e state;

    logic [WC_W-1:0] word_cnt;
    logic [RC_W-1:0] row_cnt;
    logic            accepted;
    logic            last_word;

    assign out_valid = (state == ac_ctrl_pkg::TX_HOLD);
    assign accepted  = out_valid && out_tready;
    assign ob_rd     = (!out_valid || accepted) && !ob_empty;
    assign last_word = (word_cnt == WC_W'(WPR - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ac_ctrl_pkg::TX_EMPTY;
        end else if (ob_rd) begin
            state <= ac_ctrl_pkg::TX_HOLD;
        end else if (accepted) begin
            state <= ac_ctrl_pkg::TX_EMPTY;
        end
    end

    always_ff @(posedge clk) begin
        if (ob_rd) begin
            out_beat.data  <= ob_word;
            out_beat.tuser <= (word_cnt == '0) && (row_cnt == '0);
            out_beat.tlast <= last_word;
        end
    end

    // Word and row position of the next loaded word
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            word_cnt <= '0;
            row_cnt  <= '0;
        end else if (ob_rd) begin
            if (last_word) begin
                word_cnt <= '0;
                row_cnt  <= (row_cnt == RC_W'(`AC_IMG_H - 1)) ? '0 : row_cnt + 1'b1;
            end else begin
                word_cnt <= word_cnt + 1'b1;
            end
        end
    end

endmodule
